/* Makefile */
VERILATOR ?= verilator
TOP       ?= alu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/alu_clkgen.sv */
`default_nettype none

module alu_clkgen (
   output logic o_clk,
   output logic o_nrst
);

   // 8 unit period
   initial begin
      o_clk = 1'b0;
      forever #4 o_clk = ~o_clk;
   end

   // release one unit after the second rising edge, like the other inputs
   initial begin
      o_nrst = 1'b0;
      repeat (2) @(posedge o_clk);
      #1;
      o_nrst = 1'b1;
   end

endmodule

`default_nettype wire

/* bench/alu_tb.sv */
`default_nettype none

module alu_tb;

   localparam int TIMEOUT = 200;
   localparam int MAX_VAL = 2 ** (alu_pkg::DATA_WIDTH - 1) - 1;
   localparam int MIN_VAL = -(2 ** (alu_pkg::DATA_WIDTH - 1));
   localparam int PUSH_LIMIT = alu_pkg::CMD_DEPTH + alu_pkg::RES_DEPTH + 1;

   logic                 clk;
   logic                 nrst;
   logic                 i_cmd_push;
   alu_pkg::alu_cmd_t    i_cmd;
   logic                 o_cmd_full;
   logic                 o_res_valid;
   alu_pkg::alu_result_t o_res;
   logic                 i_res_pop;

   int errors;
   int checks;
   int tests;
   bit timed_out;

   // expected results in push order
   alu_pkg::alu_result_t exp_q[$];

   alu_clkgen u_clkgen (
      .o_clk  (clk),
      .o_nrst (nrst)
   );

   alu_top u_dut (
      .i_clk       (clk),
      .i_nrst      (nrst),
      .i_cmd_push  (i_cmd_push),
      .i_cmd       (i_cmd),
      .o_cmd_full  (o_cmd_full),
      .o_res_valid (o_res_valid),
      .o_res       (o_res),
      .i_res_pop   (i_res_pop)
   );

   // reference model on plain integers
   function automatic alu_pkg::alu_result_t expected_result(input alu_pkg::alu_cmd_t cmd);
      alu_pkg::alu_result_t r;
      int a;
      int b;
      int v;
      r = '0;
      a = $signed(cmd.a);
      b = $signed(cmd.b);
      v = 0;
      case (cmd.op)
         alu_pkg::OP_ADD: begin
            v = a + b;
            r.ovf = (v > MAX_VAL) || (v < MIN_VAL);
         end
         alu_pkg::OP_SUB: begin
            v = a - b;
            r.ovf = (v > MAX_VAL) || (v < MIN_VAL);
         end
         alu_pkg::OP_MUL: begin
            if (a == MIN_VAL || b == MIN_VAL) begin
               r.ovf = 1'b1;
            end else begin
               v = a * b;
               // the limit is on magnitude so -32768 overflows too
               r.ovf = (v > MAX_VAL) || (v < -MAX_VAL);
            end
         end
         default: begin
            if (b == 0) begin
               r.div_zero = 1'b1;
            end else if (a == MIN_VAL || b == MIN_VAL) begin
               r.ovf = 1'b1;
            end else begin
               v = a / b;
            end
         end
      endcase
      r.q = v[alu_pkg::DATA_WIDTH-1:0];
      return r;
   endfunction

   task automatic compare_result(input alu_pkg::alu_result_t exp,
                                 input alu_pkg::alu_result_t act);
      checks++;
      if (act.ovf !== exp.ovf || act.div_zero !== exp.div_zero ||
          (!exp.ovf && !exp.div_zero && act.q !== exp.q)) begin
         errors++;
         $display("MISMATCH at %0t: exp q=%0d ovf=%b div_zero=%b, act q=%0d ovf=%b div_zero=%b",
                  $time, exp.q, exp.ovf, exp.div_zero, act.q, act.ovf, act.div_zero);
      end
   endtask

   task automatic compare_flag(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
      end
   endtask

   task automatic push_cmd(input alu_pkg::alu_op_e op,
                           input logic signed [alu_pkg::DATA_WIDTH-1:0] a,
                           input logic signed [alu_pkg::DATA_WIDTH-1:0] b);
      alu_pkg::alu_cmd_t cmd;
      int n;
      cmd.op = op;
      cmd.a = a;
      cmd.b = b;
      n = 0;
      if (timed_out) return;
      while (o_cmd_full && n < TIMEOUT) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (o_cmd_full) begin
         timed_out = 1'b1;
         $display("timeout: o_cmd_full stayed high for %0d cycles", TIMEOUT);
         return;
      end
      i_cmd = cmd;
      i_cmd_push = 1'b1;
      @(posedge clk);
      #1;
      i_cmd_push = 1'b0;
      exp_q.push_back(expected_result(cmd));
   endtask

   task automatic pop_and_compare();
      alu_pkg::alu_result_t act;
      int n;
      n = 0;
      if (timed_out) return;
      while (!o_res_valid && n < TIMEOUT) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!o_res_valid) begin
         timed_out = 1'b1;
         $display("timeout: o_res_valid did not rise within %0d cycles", TIMEOUT);
         return;
      end
      act = o_res;
      if (exp_q.size() == 0) begin
         errors++;
         $display("a result came out with no command outstanding at %0t", $time);
      end else begin
         compare_result(exp_q.pop_front(), act);
      end
      i_res_pop = 1'b1;
      @(posedge clk);
      #1;
      i_res_pop = 1'b0;
   endtask

   task automatic single_op(input alu_pkg::alu_op_e op,
                            input logic signed [alu_pkg::DATA_WIDTH-1:0] a,
                            input logic signed [alu_pkg::DATA_WIDTH-1:0] b);
      push_cmd(op, a, b);
      pop_and_compare();
   endtask

   task automatic report_test(input string name, input int err_before);
      tests++;
      if (timed_out) begin
         $display("test %s: stopped by timeout", name);
      end else if (errors == err_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - err_before);
      end
   endtask

   task automatic verify_reset_state();
      int e0;
      e0 = errors;
      compare_flag("o_res_valid after reset", 1'b0, o_res_valid);
      compare_flag("o_cmd_full after reset", 1'b0, o_cmd_full);
      report_test("reset", e0);
   endtask

   task automatic exercise_add_sub();
      logic signed [alu_pkg::DATA_WIDTH-1:0] ra;
      logic signed [alu_pkg::DATA_WIDTH-1:0] rb;
      int e0;
      e0 = errors;
      single_op(alu_pkg::OP_ADD, 100, 23);
      single_op(alu_pkg::OP_ADD, -100, 23);
      single_op(alu_pkg::OP_ADD, -5, -7);
      single_op(alu_pkg::OP_ADD, 32767, 1);
      single_op(alu_pkg::OP_ADD, -32768, -1);
      single_op(alu_pkg::OP_SUB, 100, 23);
      single_op(alu_pkg::OP_SUB, -100, -23);
      single_op(alu_pkg::OP_SUB, 32767, -1);
      single_op(alu_pkg::OP_SUB, -32768, 1);
      single_op(alu_pkg::OP_SUB, 0, -32768);
      for (int i = 0; i < 20; i++) begin
         ra = 16'($urandom);
         rb = 16'($urandom);
         single_op(alu_pkg::OP_ADD, ra, rb);
         single_op(alu_pkg::OP_SUB, ra, rb);
      end
      report_test("add_sub", e0);
   endtask

   task automatic multiply_cases();
      logic signed [alu_pkg::DATA_WIDTH-1:0] ra;
      logic signed [alu_pkg::DATA_WIDTH-1:0] rb;
      int e0;
      e0 = errors;
      single_op(alu_pkg::OP_MUL, 7, 6);
      single_op(alu_pkg::OP_MUL, -7, 6);
      single_op(alu_pkg::OP_MUL, 7, -6);
      single_op(alu_pkg::OP_MUL, -7, -6);
      single_op(alu_pkg::OP_MUL, 0, 1234);
      single_op(alu_pkg::OP_MUL, -1234, 0);
      single_op(alu_pkg::OP_MUL, 1, -999);
      single_op(alu_pkg::OP_MUL, -1, 999);
      single_op(alu_pkg::OP_MUL, -32768, 1);
      single_op(alu_pkg::OP_MUL, 0, -32768);
      single_op(alu_pkg::OP_MUL, -32768, -1);
      // 32761 and 32767 fit while 32768 and 40000 overflow
      single_op(alu_pkg::OP_MUL, 181, 181);
      single_op(alu_pkg::OP_MUL, -7, -4681);
      single_op(alu_pkg::OP_MUL, 256, 128);
      single_op(alu_pkg::OP_MUL, -256, 128);
      single_op(alu_pkg::OP_MUL, 200, 200);
      for (int i = 0; i < 12; i++) begin
         ra = 16'($signed(8'($urandom)));
         rb = 16'($signed(8'($urandom)));
         single_op(alu_pkg::OP_MUL, ra, rb);
      end
      report_test("multiply", e0);
   endtask

   task automatic divide_cases();
      logic signed [alu_pkg::DATA_WIDTH-1:0] ra;
      logic signed [alu_pkg::DATA_WIDTH-1:0] rb;
      int e0;
      e0 = errors;
      single_op(alu_pkg::OP_DIV, 100, 7);
      single_op(alu_pkg::OP_DIV, -100, 7);
      single_op(alu_pkg::OP_DIV, 100, -7);
      single_op(alu_pkg::OP_DIV, -100, -7);
      single_op(alu_pkg::OP_DIV, 7, 100);
      single_op(alu_pkg::OP_DIV, -7, 2);
      single_op(alu_pkg::OP_DIV, 32767, -1);
      single_op(alu_pkg::OP_DIV, 5, 0);
      single_op(alu_pkg::OP_DIV, -32768, 0);
      single_op(alu_pkg::OP_DIV, -32768, 3);
      single_op(alu_pkg::OP_DIV, 3, -32768);
      for (int i = 0; i < 12; i++) begin
         ra = 16'($urandom);
         rb = 16'($signed(12'($urandom)));
         single_op(alu_pkg::OP_DIV, ra, rb);
      end
      report_test("divide", e0);
   endtask

   task automatic queue_order();
      int e0;
      e0 = errors;
      push_cmd(alu_pkg::OP_MUL, -123, 45);
      push_cmd(alu_pkg::OP_ADD, 1000, -3000);
      push_cmd(alu_pkg::OP_DIV, 9999, -13);
      push_cmd(alu_pkg::OP_SUB, -32768, 5);
      repeat (4) pop_and_compare();
      report_test("queue_order", e0);
   endtask

   task automatic backpressure();
      logic signed [alu_pkg::DATA_WIDTH-1:0] ra;
      logic signed [alu_pkg::DATA_WIDTH-1:0] rb;
      int pushed;
      int e0;
      e0 = errors;
      pushed = 0;
      while (!o_cmd_full && pushed < PUSH_LIMIT && !timed_out) begin
         ra = 16'($urandom);
         rb = 16'($signed(10'($urandom)));
         push_cmd(alu_pkg::alu_op_e'(2'($urandom)), ra, rb);
         pushed++;
      end
      if (!timed_out) begin
         compare_flag("o_cmd_full after pushes without popping", 1'b1, o_cmd_full);
      end
      while (exp_q.size() > 0 && !timed_out) begin
         pop_and_compare();
      end
      // nothing may be left once every expected result is out
      if (!timed_out) begin
         compare_flag("o_res_valid after drain", 1'b0, o_res_valid);
      end
      report_test("backpressure", e0);
   endtask

   initial begin
      int unsigned seed;
      int n;
      i_cmd_push = 1'b0;
      i_cmd = '0;
      i_res_pop = 1'b0;
      errors = 0;
      checks = 0;
      tests = 0;
      timed_out = 1'b0;
      seed = $urandom(32'h5525);
      n = 0;
      while (!nrst && n < 10) begin
         @(posedge clk);
         n++;
      end
      #1;
      if (!nrst) begin
         timed_out = 1'b1;
         $display("reset was never released");
      end
      verify_reset_state();
      exercise_add_sub();
      multiply_cases();
      divide_cases();
      queue_order();
      backpressure();
      $display("tests %0d, checks %0d, errors %0d, timeout %0d",
               tests, checks, errors, timed_out);
      if (errors == 0 && !timed_out) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* design/adder.sv */
`default_nettype none

module adder (
   input  wire  signed [alu_pkg::DATA_WIDTH-1:0] i_a,
   input  wire  signed [alu_pkg::DATA_WIDTH-1:0] i_b,
   output wire  signed [alu_pkg::DATA_WIDTH-1:0] o_q,
   output wire                                   o_ovf
);

   wire sign_a;
   wire sign_b;
   wire sign_q;

   assign o_q = i_a + i_b;

   assign sign_a = i_a[alu_pkg::DATA_WIDTH-1];
   assign sign_b = i_b[alu_pkg::DATA_WIDTH-1];
   assign sign_q = o_q[alu_pkg::DATA_WIDTH-1];

   // like-signed operands giving a result of the other sign
   assign o_ovf = (sign_a == sign_b) && (sign_q != sign_a);

endmodule

`default_nettype wire

/* design/alu_pkg.sv */
`default_nettype none

package alu_pkg;

   // operand and result width
   localparam int DATA_WIDTH = 16;

   // queue sizes in entries
   localparam int CMD_DEPTH = 4;
   localparam int RES_DEPTH = 4;

   typedef enum logic [1:0] {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_MUL = 2'd2,
      OP_DIV = 2'd3
   } alu_op_e;

   // one queued operation, 34 bits
   typedef struct packed {
      alu_op_e                      op;
      logic signed [DATA_WIDTH-1:0] a;
      logic signed [DATA_WIDTH-1:0] b;
   } alu_cmd_t;

   // one finished operation, 18 bits
   // q is meaningless when either flag is set
   typedef struct packed {
      logic signed [DATA_WIDTH-1:0] q;
      logic                         ovf;
      logic                         div_zero;
   } alu_result_t;

endpackage

`default_nettype wire

/* design/alu_top.sv */
`default_nettype none

module alu_top (
   input  wire                    i_clk,
   input  wire                    i_nrst,
   input  wire                    i_cmd_push,
   input  wire alu_pkg::alu_cmd_t i_cmd,
   output logic                   o_cmd_full,
   output logic                   o_res_valid,
   output alu_pkg::alu_result_t   o_res,
   input  wire                    i_res_pop
);

   alu_pkg::alu_cmd_t                    head_cmd;
   alu_pkg::alu_cmd_t                    issue_cmd;
   alu_pkg::alu_result_t                 alu_res;
   logic                                 cmd_empty;
   logic                                 res_empty;
   logic                                 res_full;
   logic                                 issue;
   logic                                 issue_vld;
   logic [3:0]                           strobe;
   logic signed [alu_pkg::DATA_WIDTH-1:0] alu_q;
   logic                                 alu_ovf;
   logic                                 alu_div_zero;
   logic                                 alu_accept;
   logic                                 alu_busy;

   sync_fifo #(
      .T_DATA (alu_pkg::alu_cmd_t),
      .DEPTH  (alu_pkg::CMD_DEPTH)
   ) u_cmd_fifo (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_push  (i_cmd_push),
      .i_data  (i_cmd),
      .i_pop   (issue),
      .o_data  (head_cmd),
      .o_empty (cmd_empty),
      .o_full  (o_cmd_full)
   );

   // one operation in flight, so free space now still holds at accept
   assign issue = ~cmd_empty & ~alu_busy & ~res_full & ~issue_vld;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         issue_vld <= 1'b0;
      end else begin
         issue_vld <= issue;
      end
   end

   always_ff @(posedge i_clk) begin
      if (issue) begin
         issue_cmd <= head_cmd;
      end
   end

   // op code to one-hot strobe, add sub mul div from bit 0 up
   always_comb begin
      strobe = '0;
      if (issue_vld) begin
         case (issue_cmd.op)
            alu_pkg::OP_ADD: strobe[0] = 1'b1;
            alu_pkg::OP_SUB: strobe[1] = 1'b1;
            alu_pkg::OP_MUL: strobe[2] = 1'b1;
            alu_pkg::OP_DIV: strobe[3] = 1'b1;
            default:         strobe    = '0;
         endcase
      end
   end

   sequential_alu u_alu (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_a        (issue_cmd.a),
      .i_b        (issue_cmd.b),
      .i_add      (strobe[0]),
      .i_sub      (strobe[1]),
      .i_mul      (strobe[2]),
      .i_div      (strobe[3]),
      .o_q        (alu_q),
      .o_ovf      (alu_ovf),
      .o_div_zero (alu_div_zero),
      .o_accept   (alu_accept),
      .o_busy     (alu_busy)
   );

   assign alu_res = '{q: alu_q, ovf: alu_ovf, div_zero: alu_div_zero};

   sync_fifo #(
      .T_DATA (alu_pkg::alu_result_t),
      .DEPTH  (alu_pkg::RES_DEPTH)
   ) u_res_fifo (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_push  (alu_accept),
      .i_data  (alu_res),
      .i_pop   (i_res_pop),
      .o_data  (o_res),
      .o_empty (res_empty),
      .o_full  (res_full)
   );

   assign o_res_valid = ~res_empty;

endmodule

`default_nettype wire

/* design/sequential_alu.sv */
`default_nettype none

module sequential_alu (
   input  wire                                   i_clk,
   input  wire                                   i_nrst,
   input  wire  signed [alu_pkg::DATA_WIDTH-1:0] i_a,
   input  wire  signed [alu_pkg::DATA_WIDTH-1:0] i_b,
   input  wire                                   i_add,
   input  wire                                   i_sub,
   input  wire                                   i_mul,
   input  wire                                   i_div,
   output logic signed [alu_pkg::DATA_WIDTH-1:0] o_q,
   output logic                                  o_ovf,
   output logic                                  o_div_zero,
   output logic                                  o_accept,
   output logic                                  o_busy
);

   typedef logic signed [alu_pkg::DATA_WIDTH-1:0] word_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SIGN_B,
      ST_SIGN_Q,
      ST_MUL,
      ST_DIV_SHIFT,
      ST_DIV_COMPARE,
      ST_DIV_COUNT
   } state_e;

   state_e state;

   // multiplier or dividend magnitude
   word_t  opa;
   // multiplicand or divisor magnitude
   word_t  opb;
   word_t  rem;
   word_t  cnt;
   logic   neg;
   logic   is_mul;

   word_t  add_a;
   word_t  add_b;
   word_t  add_q;
   logic   add_ovf;

   logic   sign_a;
   logic   sign_b;
   logic   mul_ovf;
   logic   mul_last;
   logic   div_ge;
   logic   cnt_last;

   assign sign_a = i_a[alu_pkg::DATA_WIDTH-1];
   assign sign_b = i_b[alu_pkg::DATA_WIDTH-1];

   // a shifted multiplicand past the sign bit with multiplier bits left
   assign mul_ovf  = (opb[alu_pkg::DATA_WIDTH-1] & (opa != '0)) | (opa[0] & add_ovf);
   assign mul_last = (opa[alu_pkg::DATA_WIDTH-1:1] == '0);

   // adder holds ~(rem - opb), so a set sign bit means rem >= opb
   assign div_ge   = add_q[alu_pkg::DATA_WIDTH-1];
   assign cnt_last = (cnt == word_t'(alu_pkg::DATA_WIDTH - 1));

   assign o_busy = (state != ST_IDLE) | o_accept;

   // operand steering for the one shared adder
   always_comb begin
      add_a = opa;
      add_b = word_t'(1);
      case (state)
         ST_IDLE: begin
            if (i_add) begin
               add_a = i_a;
               add_b = i_b;
            end else if (i_sub) begin
               // a - b computed as ~(~a + b)
               add_a = ~i_a;
               add_b = i_b;
            end else if (sign_a) begin
               add_a = ~i_a;
            end else begin
               add_a = ~i_b;
            end
         end
         ST_SIGN_B:      add_a = ~opb;
         ST_SIGN_Q:      add_a = ~o_q;
         ST_MUL: begin
            add_a = o_q;
            add_b = opb;
         end
         ST_DIV_COMPARE: begin
            add_a = ~rem;
            add_b = opb;
         end
         ST_DIV_COUNT:   add_a = cnt;
         default:        add_a = opa;
      endcase
   end

   adder u_adder (
      .i_a   (add_a),
      .i_b   (add_b),
      .o_q   (add_q),
      .o_ovf (add_ovf)
   );

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state      <= ST_IDLE;
         o_q        <= '0;
         o_ovf      <= 1'b0;
         o_div_zero <= 1'b0;
         o_accept   <= 1'b0;
         opa        <= '0;
         opb        <= '0;
         rem        <= '0;
         cnt        <= '0;
         neg        <= 1'b0;
         is_mul     <= 1'b0;
      end else begin
         o_accept   <= 1'b0;
         o_ovf      <= 1'b0;
         o_div_zero <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (i_add | i_sub) begin
                  o_q      <= i_add ? add_q : ~add_q;
                  o_ovf    <= add_ovf;
                  o_accept <= 1'b1;
               end else if (i_div & (i_b == '0)) begin
                  o_q        <= '0;
                  o_div_zero <= 1'b1;
                  o_accept   <= 1'b1;
               end else if (i_mul | i_div) begin
                  o_q    <= '0;
                  rem    <= '0;
                  cnt    <= '0;
                  opa    <= sign_a ? add_q : i_a;
                  opb    <= (sign_b & ~sign_a) ? add_q : i_b;
                  neg    <= sign_a ^ sign_b;
                  is_mul <= i_mul;
                  // negating the most negative value has no magnitude
                  if ((sign_a | sign_b) & add_ovf) begin
                     o_ovf    <= 1'b1;
                     o_accept <= 1'b1;
                  end else if (sign_a & sign_b) begin
                     state <= ST_SIGN_B;
                  end else begin
                     state <= i_mul ? ST_MUL : ST_DIV_SHIFT;
                  end
               end
            end
            ST_SIGN_B: begin
               opb <= add_q;
               if (add_ovf) begin
                  o_ovf    <= 1'b1;
                  o_accept <= 1'b1;
                  state    <= ST_IDLE;
               end else begin
                  state <= is_mul ? ST_MUL : ST_DIV_SHIFT;
               end
            end
            ST_SIGN_Q: begin
               o_q      <= add_q;
               o_accept <= 1'b1;
               state    <= ST_IDLE;
            end
            ST_MUL: begin
               if (mul_ovf) begin
                  o_ovf    <= 1'b1;
                  o_accept <= 1'b1;
                  state    <= ST_IDLE;
               end else begin
                  if (opa[0]) begin
                     o_q <= add_q;
                  end
                  opa <= opa >> 1;
                  opb <= opb << 1;
                  if (mul_last) begin
                     if (neg) begin
                        state <= ST_SIGN_Q;
                     end else begin
                        o_accept <= 1'b1;
                        state    <= ST_IDLE;
                     end
                  end
               end
            end
            ST_DIV_SHIFT: begin
               rem   <= {rem[alu_pkg::DATA_WIDTH-2:0], opa[alu_pkg::DATA_WIDTH-1]};
               opa   <= opa << 1;
               state <= ST_DIV_COMPARE;
            end
            ST_DIV_COMPARE: begin
               // restore by simply keeping the old remainder
               if (div_ge) begin
                  rem <= ~add_q;
               end
               o_q   <= {o_q[alu_pkg::DATA_WIDTH-2:0], div_ge};
               state <= ST_DIV_COUNT;
            end
            ST_DIV_COUNT: begin
               if (cnt_last) begin
                  if (neg) begin
                     state <= ST_SIGN_Q;
                  end else begin
                     o_accept <= 1'b1;
                     state    <= ST_IDLE;
                  end
               end else begin
                  cnt   <= add_q;
                  state <= ST_DIV_SHIFT;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // the issuing logic upstream must keep strobes one-hot
   a_one_strobe: assert property (@(posedge i_clk) disable iff (!i_nrst)
      $onehot0({i_add, i_sub, i_mul, i_div}))
      else $error("sequential_alu: several operation strobes in one cycle");

   a_no_strobe_busy: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_busy |-> !(i_add | i_sub | i_mul | i_div))
      else $error("sequential_alu: operation strobe while busy");

   a_accept_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_accept |=> !o_accept)
      else $error("sequential_alu: accept held for two cycles");

endmodule

`default_nettype wire

/* design/sync_fifo.sv */
`default_nettype none

module sync_fifo #(
   parameter type T_DATA = logic,
   parameter int  DEPTH  = 4
) (
   input  wire        i_clk,
   input  wire        i_nrst,
   input  wire        i_push,
   input  wire T_DATA i_data,
   input  wire        i_pop,
   output T_DATA      o_data,
   output logic       o_empty,
   output logic       o_full
);

   typedef logic [$clog2(DEPTH)-1:0] ptr_t;
   typedef logic [$clog2(DEPTH):0]   cnt_t;

   T_DATA mem [DEPTH];
   ptr_t  wr_ptr;
   ptr_t  rd_ptr;
   cnt_t  count;
   logic  do_push;
   logic  do_pop;

   assign do_push = i_push & ~o_full;
   assign do_pop  = i_pop & ~o_empty;

   assign o_empty = (count == '0);
   assign o_full  = (count == cnt_t'(DEPTH));
   assign o_data  = mem[rd_ptr];

   always_ff @(posedge i_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // pointers wrap at DEPTH so any depth works
         if (do_push) begin
            wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + ptr_t'(1);
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + ptr_t'(1);
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + cnt_t'(1);
            2'b01:   count <= count - cnt_t'(1);
            default: count <= count;
         endcase
      end
   end

   a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_push |-> !o_full)
      else $error("sync_fifo: push while full");

   a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_pop |-> !o_empty)
      else $error("sync_fifo: pop while empty");

endmodule

`default_nettype wire

/* verilog.f */
design/alu_pkg.sv
design/adder.sv
design/sequential_alu.sv
design/sync_fifo.sv
design/alu_top.sv
bench/alu_clkgen.sv
bench/alu_tb.sv
